// ==== mdr_cfg.svh ====
`ifndef MDR_CFG_SVH
`define MDR_CFG_SVH

// operand width, any even value of 4 or more
`define MDR_WIDTH 8

// square root retires two radicand bits per step
`define MDR_SQRT_STEPS_DIV 2

// value of result and remainder out of reset
`define MDR_OUT_RST '0

`endif

// ==== mdr_pkg.sv ====
`default_nettype none

package mdr_pkg;

	// operation select, as driven on the op port
	typedef enum logic [1:0] {
		OP_MUL  = 2'd0,
		OP_DIV  = 2'd1,
		OP_SQRT = 2'd2
	} op_e;

	// sequencer states
	typedef enum logic [1:0] {
		ST_IDLE = 2'd0,
		ST_RUN  = 2'd1,  // init cycle, then the steps
		ST_DONE = 2'd2   // one cycle, done pulse
	} seq_state_e;

endpackage

`default_nettype wire

// ==== operand_loader.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mdr_cfg.svh"

module operand_loader #(
	parameter int N = `MDR_WIDTH
) (
	input  logic         clk,
	input  logic         arst_n,
	input  logic         load,
	input  logic         busy,
	input  logic         clear,
	input  logic [N-1:0] data,
	output logic [N-1:0] opnd_a,
	output logic [N-1:0] opnd_b,
	output logic         a_valid,
	output logic         b_valid
);

	logic sel_b_q;  // next load goes to b
	logic cap;
	logic cap_a;
	logic cap_b;

	assign cap   = load && !busy;       // loads are dropped while an op runs
	assign cap_a = cap && !sel_b_q;
	assign cap_b = cap && sel_b_q;

	always_ff @(posedge clk) begin
		if (cap_a)
			opnd_a <= data;
		if (cap_b)
			opnd_b <= data;
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			sel_b_q <= 1'b0;
			a_valid <= 1'b0;
			b_valid <= 1'b0;
		end else if (clear) begin
			sel_b_q <= 1'b0;  // operands consumed by the launch
			a_valid <= 1'b0;
			b_valid <= 1'b0;
		end else if (cap_a) begin
			sel_b_q <= 1'b1;
			a_valid <= 1'b1;
			b_valid <= 1'b0;  // a fresh a starts a new pair
		end else if (cap_b) begin
			sel_b_q <= 1'b0;
			b_valid <= 1'b1;
		end
	end

	// b is only ever loaded behind a
	a_b_order: assert property (@(posedge clk) disable iff (!arst_n) b_valid |-> a_valid);

endmodule

`default_nettype wire

// ==== mdr_sequencer.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mdr_cfg.svh"

module mdr_sequencer #(
	parameter int N = `MDR_WIDTH
) (
	input  logic         clk,
	input  logic         arst_n,
	input  logic         start,
	input  logic         a_valid,
	input  logic         b_valid,
	input  mdr_pkg::op_e op,
	output mdr_pkg::op_e op_q,
	output logic         init,
	output logic         step_en,
	output logic         busy,
	output logic         done
);

	import mdr_pkg::*;

	localparam int CW = $clog2(N) + 1;

	// step counts, one per bit for mul/div, one per bit pair for root
	localparam logic [CW-1:0] STEPS_FULL = CW'(N);
	localparam logic [CW-1:0] STEPS_ROOT = CW'(N / `MDR_SQRT_STEPS_DIV);

	seq_state_e    state_q;
	logic [CW-1:0] cnt_q;
	logic          init_q;
	logic          ready;
	logic          accept;
	logic          last_step;

	// root needs only a, the others need both operands
	assign ready  = a_valid && ((op == OP_SQRT) || b_valid);
	assign accept = (state_q == ST_IDLE) && start && ready;

	assign step_en   = (state_q == ST_RUN) && !init_q;
	assign last_step = step_en && (cnt_q == CW'(1));

	assign init = init_q;
	assign busy = (state_q != ST_IDLE);
	assign done = (state_q == ST_DONE);

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state_q <= ST_IDLE;
			cnt_q   <= '0;
			init_q  <= 1'b0;
			op_q    <= OP_MUL;
		end else begin
			init_q <= accept;  // datapath loads one cycle after accept
			case (state_q)
				ST_IDLE: begin
					if (accept) begin
						state_q <= ST_RUN;
						op_q    <= op;
						cnt_q   <= (op == OP_SQRT) ? STEPS_ROOT : STEPS_FULL;
					end
				end
				ST_RUN: begin
					if (step_en) begin
						cnt_q <= cnt_q - 1'b1;
						if (last_step)
							state_q <= ST_DONE;
					end
				end
				ST_DONE: begin
					state_q <= ST_IDLE;  // results stay in the datapath
				end
				default: begin
					state_q <= ST_IDLE;
				end
			endcase
		end
	end

	// done is a single pulse
	done_pulse: assert property (@(posedge clk) disable iff (!arst_n) done |=> !done);

	// steps only run inside ST_RUN with work left on the counter
	step_in_run: assert property (@(posedge clk) disable iff (!arst_n)
		step_en |-> (state_q == ST_RUN) && (cnt_q != '0));

endmodule

`default_nettype wire

// ==== mdr_datapath.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mdr_cfg.svh"

module mdr_datapath #(
	parameter int N = `MDR_WIDTH
) (
	input  logic         clk,
	input  logic         arst_n,
	input  logic         init,
	input  logic         step_en,
	input  mdr_pkg::op_e op,
	input  logic [N-1:0] opnd_a,
	input  logic [N-1:0] opnd_b,
	output logic [N-1:0] result,
	output logic [N-1:0] remainder
);

	import mdr_pkg::*;

	localparam int AQW = 2*N + 1;

	// working register laid out as {A[N:0], Q[N-1:0]}
	logic [AQW-1:0] aq_q;
	logic [AQW-1:0] aq_d;
	logic [N-1:0]   m_q;   // divisor, multiplicand or radicand
	logic [N-1:0]   m_d;

	logic [N:0]     a_part;
	logic [N-1:0]   q_part;

	logic [N:0]     mul_sum;
	logic [AQW-1:0] mul_aq;

	logic [N:0]     trial_x;     // shifted partial remainder
	logic [N+1:0]   trial_y;     // divisor or partial root with 01
	logic [N+1:0]   trial_diff;
	logic           trial_neg;
	logic [N:0]     a_next;
	logic [AQW-1:0] rst_aq;      // restoring step, shared by div and root

	assign a_part = aq_q[AQW-1:N];
	assign q_part = aq_q[N-1:0];

	// shift-add multiply, Q lsb selects the add
	assign mul_sum = {1'b0, a_part[N-1:0]} + (q_part[0] ? {1'b0, m_q} : '0);
	assign mul_aq  = {1'b0, mul_sum, q_part[N-1:1]};

	always_comb begin
		if (op == OP_SQRT) begin
			trial_x = {a_part[N-2:0], m_q[N-1 -: 2]};  // next two radicand bits
			trial_y = {q_part, 2'b01};                 // 4*root + 1
		end else begin
			trial_x = {a_part[N-1:0], q_part[N-1]};    // next dividend bit
			trial_y = {2'b00, m_q};
		end
	end

	assign trial_diff = {1'b0, trial_x} - trial_y;
	assign trial_neg  = trial_diff[N+1];

	// restore on borrow, otherwise keep the difference
	assign a_next = trial_neg ? trial_x : trial_diff[N:0];

	// new quotient or root bit enters at the bottom of Q
	assign rst_aq = {a_next, q_part[N-2:0], ~trial_neg};

	always_comb begin
		aq_d = aq_q;
		m_d  = m_q;
		if (init) begin
			aq_d = '0;
			if (op == OP_SQRT) begin
				m_d = opnd_a;           // root builds up in Q from zero
			end else begin
				aq_d[N-1:0] = opnd_a;
				m_d         = opnd_b;
			end
		end else if (step_en) begin
			case (op)
				OP_MUL: begin
					aq_d = mul_aq;
				end
				OP_DIV: begin
					aq_d = rst_aq;
				end
				OP_SQRT: begin
					aq_d = rst_aq;
					m_d  = {m_q[N-3:0], 2'b00};  // consume the radicand pair
				end
				default: begin
					aq_d = aq_q;
				end
			endcase
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n)
			aq_q <= `MDR_OUT_RST;
		else
			aq_q <= aq_d;
	end

	always_ff @(posedge clk) begin
		m_q <= m_d;
	end

	// mul: high/low product, div: rem/quot, root: rem/root
	assign result    = q_part;
	assign remainder = a_part[N-1:0];

	// the sequencer never launches into a running step
	no_init_in_step: assert property (@(posedge clk) disable iff (!arst_n)
		!(init && step_en));

endmodule

`default_nettype wire

// ==== mdr_top.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mdr_cfg.svh"

module mdr_top #(
	parameter int N = `MDR_WIDTH
) (
	input  logic         clk,
	input  logic         arst_n,
	input  logic         load,
	input  logic         start,
	input  mdr_pkg::op_e op,
	input  logic [N-1:0] data,
	output logic         busy,
	output logic         done,
	output logic [N-1:0] result,
	output logic [N-1:0] remainder
);

	import mdr_pkg::*;

	logic [N-1:0] opnd_a;
	logic [N-1:0] opnd_b;
	logic         a_valid;
	logic         b_valid;
	logic         init;
	logic         step_en;
	op_e          op_q;     // op latched at launch

	operand_loader #(.N(N)) u_loader (
		.clk     (clk),
		.arst_n  (arst_n),
		.load    (load),
		.busy    (busy),
		.clear   (init),
		.data    (data),
		.opnd_a  (opnd_a),
		.opnd_b  (opnd_b),
		.a_valid (a_valid),
		.b_valid (b_valid)
	);

	mdr_sequencer #(.N(N)) u_seq (
		.clk     (clk),
		.arst_n  (arst_n),
		.start   (start),
		.a_valid (a_valid),
		.b_valid (b_valid),
		.op      (op),
		.op_q    (op_q),
		.init    (init),
		.step_en (step_en),
		.busy    (busy),
		.done    (done)
	);

	mdr_datapath #(.N(N)) u_dp (
		.clk       (clk),
		.arst_n    (arst_n),
		.init      (init),
		.step_en   (step_en),
		.op        (op_q),
		.opnd_a    (opnd_a),
		.opnd_b    (opnd_b),
		.result    (result),
		.remainder (remainder)
	);

endmodule

`default_nettype wire

// ==== tb_mdr.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mdr_cfg.svh"

module tb_mdr;

	import mdr_pkg::*;

	localparam int N            = `MDR_WIDTH;
	localparam int CLK_HALF     = 20;
	localparam int RST_CYC      = 8;
	localparam int N_DIR        = 14;
	localparam int N_RAND       = 16;
	localparam int N_TESTS      = N_DIR + N_RAND;
	localparam int CYC_PER_TEST = 20;
	localparam int MAX_WAIT     = N + 4;  // cycles allowed from start to done
	localparam logic [N-1:0] ALL_ONES = '1;

	typedef struct packed {
		op_e          op;
		logic [N-1:0] a;
		logic [N-1:0] b;
		logic         extra;  // second start and a stray load while busy
		logic [N-1:0] exp_res;
		logic [N-1:0] exp_rem;
	} entry_t;

	logic         clk;
	logic         arst_n;
	logic         load;
	logic         start;
	op_e          op;
	logic [N-1:0] data;
	logic         busy;
	logic         done;
	logic [N-1:0] result;
	logic [N-1:0] remainder;

	entry_t tbl [N_TESTS];
	int     seed;
	int     errors;
	int     n_pass;
	int     n_fail;

	mdr_top #(.N(N)) UUT (
		.clk       (clk),
		.arst_n    (arst_n),
		.load      (load),
		.start     (start),
		.op        (op),
		.data      (data),
		.busy      (busy),
		.done      (done),
		.result    (result),
		.remainder (remainder)
	);

	initial begin
		clk = 1'b0;
		forever #CLK_HALF clk = ~clk;
	end

	// each test gets CYC_PER_TEST cycles on top of the reset time
	initial begin
		#((N_TESTS * CYC_PER_TEST + RST_CYC) * 2 * CLK_HALF);
		$display("watchdog expired, the tests did not finish in time");
		$display("Simulation failed");
		$finish;
	end

	task automatic check_word(input string name, input logic [N-1:0] exp,
	                          input logic [N-1:0] act);
		if (act !== exp) begin
			$display("[FAIL] t=%0t %s expected %0h got %0h", $time, name, exp, act);
			errors++;
		end
	endtask

	task automatic check_bit(input string name, input logic exp, input logic act);
		if (act !== exp) begin
			$display("[FAIL] t=%0t %s expected %b got %b", $time, name, exp, act);
			errors++;
		end
	endtask

	task automatic check_op(input string name, input op_e exp, input op_e act);
		if (act !== exp) begin
			$display("[FAIL] t=%0t %s expected %s got %s", $time, name,
			         exp.name(), act.name());
			errors++;
		end
	endtask

	task automatic check_count(input string name, input int exp, input int act);
		if (act != exp) begin
			$display("[FAIL] t=%0t %s expected %0d got %0d", $time, name, exp, act);
			errors++;
		end
	endtask

	// expected values for one table entry
	function automatic entry_t make_entry(input op_e o, input longint a, input longint b,
	                                      input logic extra);
		entry_t e;
		longint ua;
		longint ub;
		longint prod;
		longint root;
		e       = '0;
		e.op    = o;
		e.a     = N'(a);
		e.b     = N'(b);
		e.extra = extra;
		ua      = longint'(e.a);
		ub      = longint'(e.b);
		case (o)
			OP_MUL: begin
				prod      = ua * ub;
				e.exp_res = N'(prod);       // low half
				e.exp_rem = N'(prod >> N);  // high half
			end
			OP_DIV: begin
				if (ub == 0) begin
					e.exp_res = ALL_ONES;
					e.exp_rem = e.a;
				end else begin
					e.exp_res = N'(ua / ub);
					e.exp_rem = N'(ua % ub);
				end
			end
			default: begin
				root = 0;
				while ((root + 1) * (root + 1) <= ua)
					root++;
				e.exp_res = N'(root);
				e.exp_rem = N'(ua - root * root);
			end
		endcase
		return e;
	endfunction

	task automatic build_table();
		int   i;
		op_e  o;
		logic [N-1:0] a;
		logic [N-1:0] b;
		tbl[0]  = make_entry(OP_MUL, 3, 5, 1'b0);
		tbl[1]  = make_entry(OP_MUL, ALL_ONES, ALL_ONES, 1'b1);
		tbl[2]  = make_entry(OP_MUL, 'h5a, 0, 1'b0);
		tbl[3]  = make_entry(OP_MUL, ALL_ONES, 1, 1'b0);
		tbl[4]  = make_entry(OP_DIV, 200, 7, 1'b0);
		tbl[5]  = make_entry(OP_DIV, 5, 9, 1'b1);     // divisor above dividend
		tbl[6]  = make_entry(OP_DIV, 100, 0, 1'b0);   // divide by zero
		tbl[7]  = make_entry(OP_DIV, ALL_ONES, 1, 1'b0);
		tbl[8]  = make_entry(OP_SQRT, 0, 0, 1'b0);
		tbl[9]  = make_entry(OP_SQRT, 1, 0, 1'b0);
		tbl[10] = make_entry(OP_SQRT, ALL_ONES, 0, 1'b1);
		tbl[11] = make_entry(OP_SQRT, 144, 0, 1'b0);
		tbl[12] = make_entry(OP_SQRT, 169, 0, 1'b0);
		tbl[13] = make_entry(OP_DIV, ALL_ONES, ALL_ONES, 1'b0);
		for (i = N_DIR; i < N_TESTS; i++) begin
			case ($unsigned($random(seed)) % 3)
				0: o = OP_MUL;
				1: o = OP_DIV;
				default: o = OP_SQRT;
			endcase
			a = N'($random(seed));
			do
				b = N'($random(seed));
			while (b == '0);
			tbl[i] = make_entry(o, a, b, 1'b0);
		end
	endtask

	task automatic run_entry(input int idx);
		entry_t e;
		int     steps;
		int     cycles;
		int     err0;
		logic   seen_done;
		e     = tbl[idx];
		err0  = errors;
		steps = (e.op == OP_SQRT) ? N / 2 : N;
		load  = 1'b1;
		data  = e.a;
		@(posedge clk);
		#2;
		if (e.op != OP_SQRT) begin
			data = e.b;
			@(posedge clk);
			#2;
		end
		load  = 1'b0;
		data  = '0;
		op    = e.op;
		start = 1'b1;
		@(posedge clk);  // start edge
		#2;
		start = 1'b0;
		check_bit("busy", 1'b1, busy);
		cycles    = 0;
		seen_done = 1'b0;
		while (!seen_done && cycles < MAX_WAIT) begin
			if (e.extra && cycles < 2) begin
				start = 1'b1;  // all of this must be ignored
				load  = 1'b1;
				data  = ~e.a;
				op    = (e.op == OP_MUL) ? OP_DIV : OP_MUL;
			end
			@(posedge clk);
			#2;
			start = 1'b0;
			load  = 1'b0;
			data  = '0;
			cycles++;
			if (done)
				seen_done = 1'b1;
			else
				check_bit("busy", 1'b1, busy);
		end
		if (!seen_done) begin
			$display("done never came within %0d cycles of start in test %0d",
			         MAX_WAIT, idx);
			errors++;
		end else begin
			check_count("start to done edges", steps + 1, cycles);
			check_word("result", e.exp_res, result);
			check_word("remainder", e.exp_rem, remainder);
			check_op("op_q", e.op, UUT.op_q);
			@(posedge clk);
			#2;
			check_bit("done", 1'b0, done);  // single cycle pulse
			check_bit("busy", 1'b0, busy);
			check_word("result", e.exp_res, result);
			check_word("remainder", e.exp_rem, remainder);
			if (e.extra) begin
				// operands were used up and a bare start must not launch
				op    = OP_SQRT;
				start = 1'b1;
				@(posedge clk);
				#2;
				start = 1'b0;
				check_bit("busy", 1'b0, busy);
				check_word("result", e.exp_res, result);
			end
		end
		if (errors == err0) begin
			n_pass++;
			$display("test %0d %s a=%0h b=%0h ok", idx, e.op.name(), e.a, e.b);
		end else begin
			n_fail++;
			$display("test %0d %s a=%0h b=%0h FAILED", idx, e.op.name(), e.a, e.b);
		end
	endtask

	initial begin
		int i;
		int err0;
		arst_n = 1'b0;
		load   = 1'b0;
		start  = 1'b0;
		op     = OP_MUL;
		data   = '0;
		seed   = 32'hc846;
		errors = 0;
		n_pass = 0;
		n_fail = 0;
		build_table();
		repeat (RST_CYC) @(posedge clk);
		#2;
		arst_n = 1'b1;
		@(posedge clk);
		#2;
		err0 = errors;
		check_bit("busy", 1'b0, busy);
		check_bit("done", 1'b0, done);
		check_word("result", '0, result);
		check_word("remainder", '0, remainder);
		if (errors == err0) begin
			n_pass++;
			$display("reset test ok");
		end else begin
			n_fail++;
			$display("reset test FAILED");
		end
		for (i = 0; i < N_TESTS; i++)
			run_entry(i);
		$display("%0d tests passed, %0d tests failed", n_pass, n_fail);
		if (n_fail == 0 && errors == 0) begin
			$display("Simulation completed successfully");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== vlog.f ====
+incdir+.
mdr_pkg.sv
operand_loader.sv
mdr_sequencer.sv
mdr_datapath.sv
mdr_top.sv
tb_mdr.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the MDR testbench with Verilator, verdict taken from the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal --top-module tb_mdr -Mdir obj_dir -f vlog.f \
	|| { echo "RESULT: build failed"; exit 1; }

./obj_dir/Vtb_mdr 2>&1 | tee sim.log

grep -q "Simulation failed" sim.log && { echo "RESULT: FAIL"; exit 1; }
grep -q "Simulation completed successfully" sim.log && { echo "RESULT: PASS"; exit 0; } \
	|| { echo "RESULT: FAIL, no verdict in the log"; exit 1; }
